//--- common/router_macros.svh
`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

// ********************
// router field widths
// ********************

// flit identifier width.
`define FLIT_ID_W 3

// packet length and timer count width.
`define LEN_W 12

// flit word width.
`define DATA_W 32

// identifier code carried by a header flit.
`define HEADER_CODE 3'd1

`endif

//--- common/routerPkg.sv
package routerPkg;

`include "router_macros.svh"

  // ********************
  // port select
  // ********************

  // owner of the output port, one bit per state.
  // psIdle means nobody holds the output.
  typedef enum logic [5:0] {
    psIdle  = 6'b000001,
    psLocal = 6'b000010,
    psNorth = 6'b000100,
    psEast  = 6'b001000,
    psWest  = 6'b010000,
    psSouth = 6'b100000
  } portSel;

  // ********************
  // flit kinds
  // ********************

  // codes seen on the flit identifier of each input.
  // only the header code restarts a grant timer.
  typedef enum logic [`FLIT_ID_W-1:0] {
    fkBody   = 3'd0,
    fkHeader = `HEADER_CODE,
    fkTail   = 3'd2
  } flitKind;

endpackage

//--- arbiter/grantTimer.sv
`timescale 1ns/1ps

`include "router_macros.svh"

module grantTimer
  import routerPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`FLIT_ID_W-1:0] flitId,
  input  logic [`LEN_W-1:0]     length,
  input  logic                  runTimer,
  output logic                  timesUp
);

  logic [`LEN_W-1:0] limit;
  logic [`LEN_W-1:0] count;

  // limit follows the length of the latest header flit.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == fkHeader)
        limit <= length;
      // count only while this input holds the output.
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == limit);

  // ********************
  // checks
  // ********************

  // a counting cycle never carries the count past the limit.
  // a reload of the limit during a hold is excused.
  assert property (@(posedge clk) disable iff (rst)
    (runTimer && (count <= limit)) |=> (count <= limit) || $changed(limit))
  else
    $error("grantTimer: count %0d passed limit %0d", count, limit);

endmodule

//--- arbiter/switchArbiter.sv
`timescale 1ns/1ps

`include "router_macros.svh"

module switchArbiter
  import routerPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lReq,
  input  logic                  nReq,
  input  logic                  eReq,
  input  logic                  wReq,
  input  logic                  sReq,
  input  logic [`FLIT_ID_W-1:0] lFlitId,
  input  logic [`FLIT_ID_W-1:0] nFlitId,
  input  logic [`FLIT_ID_W-1:0] eFlitId,
  input  logic [`FLIT_ID_W-1:0] wFlitId,
  input  logic [`FLIT_ID_W-1:0] sFlitId,
  input  logic [`LEN_W-1:0]     lLength,
  input  logic [`LEN_W-1:0]     nLength,
  input  logic [`LEN_W-1:0]     eLength,
  input  logic [`LEN_W-1:0]     wLength,
  input  logic [`LEN_W-1:0]     sLength,
  output portSel                grant
);

  portSel     state;
  portSel     nextState;
  logic [4:0] reqVec;
  logic [4:0] timesUp;
  logic [4:0] runTimer;
  logic [2:0] holder;

  // bit order is L, N, E, W, S from bit 0 upward.
  assign reqVec = {sReq, wReq, eReq, nReq, lReq};

  // first requester found when scanning from index start, wrapping.
  function automatic portSel firstReq(input logic [4:0] reqs, input logic [2:0] start);
    int idx;
    firstReq = psIdle;
    // scan backwards so the earliest requester wins.
    for (int i = 4; i >= 0; i--)
    begin
      idx = start + i;
      if (idx >= 5)
        idx = idx - 5;
      if (reqs[idx])
        firstReq = portSel'(6'b000010 << idx);
    end
  endfunction

  // ********************
  // grant timers
  // ********************

  grantTimer i_lTimer (.clk(clk), .rst(rst), .flitId(lFlitId), .length(lLength),
                       .runTimer(runTimer[0]), .timesUp(timesUp[0]));
  grantTimer i_nTimer (.clk(clk), .rst(rst), .flitId(nFlitId), .length(nLength),
                       .runTimer(runTimer[1]), .timesUp(timesUp[1]));
  grantTimer i_eTimer (.clk(clk), .rst(rst), .flitId(eFlitId), .length(eLength),
                       .runTimer(runTimer[2]), .timesUp(timesUp[2]));
  grantTimer i_wTimer (.clk(clk), .rst(rst), .flitId(wFlitId), .length(wLength),
                       .runTimer(runTimer[3]), .timesUp(timesUp[3]));
  grantTimer i_sTimer (.clk(clk), .rst(rst), .flitId(sFlitId), .length(sLength),
                       .runTimer(runTimer[4]), .timesUp(timesUp[4]));

  // ********************
  // state machine
  // ********************

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= psIdle;
    else
      state <= nextState;
  end

  assign grant = state;

  always_comb
  begin
    case (state)
      psNorth: holder = 3'd1;
      psEast:  holder = 3'd2;
      psWest:  holder = 3'd3;
      psSouth: holder = 3'd4;
      default: holder = 3'd0;
    endcase
  end

  always_comb
  begin
    runTimer  = '0;
    nextState = psIdle;
    case (state)
      psIdle:
        nextState = firstReq(reqVec, 3'd0);
      psLocal, psNorth, psEast, psWest, psSouth:
      begin
        if (reqVec[holder] && !timesUp[holder])
        begin
          runTimer[holder] = 1'b1;
          nextState        = state;
        end
        else
          // rotate past the holder, which comes last.
          nextState = firstReq(reqVec, holder + 3'd1);
      end
      default:
        nextState = psIdle;
    endcase
  end

  // ********************
  // checks
  // ********************

  assert property (@(posedge clk) disable iff (rst)
    state inside {psIdle, psLocal, psNorth, psEast, psWest, psSouth})
  else
    $error("switchArbiter: illegal state %b", state);

  // only the holder's timer may run.
  assert property (@(posedge clk) disable iff (rst) $onehot0(runTimer))
  else
    $error("switchArbiter: several timers running %b", runTimer);

endmodule

//--- logic/flitForward.sv
`timescale 1ns/1ps

`include "router_macros.svh"

module flitForward
  import routerPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  portSel                grant,
  input  logic                  lReq,
  input  logic                  nReq,
  input  logic                  eReq,
  input  logic                  wReq,
  input  logic                  sReq,
  input  logic [`DATA_W-1:0]    lData,
  input  logic [`DATA_W-1:0]    nData,
  input  logic [`DATA_W-1:0]    eData,
  input  logic [`DATA_W-1:0]    wData,
  input  logic [`DATA_W-1:0]    sData,
  input  logic [`FLIT_ID_W-1:0] lFlitId,
  input  logic [`FLIT_ID_W-1:0] nFlitId,
  input  logic [`FLIT_ID_W-1:0] eFlitId,
  input  logic [`FLIT_ID_W-1:0] wFlitId,
  input  logic [`FLIT_ID_W-1:0] sFlitId,
  output logic [`DATA_W-1:0]    outData,
  output logic [`FLIT_ID_W-1:0] outFlitId,
  output logic                  outValid
);

  logic                  selReq;
  logic [`DATA_W-1:0]    selData;
  logic [`FLIT_ID_W-1:0] selFlitId;

  // pick the granted input.
  always_comb
  begin
    selReq    = 1'b0;
    selData   = lData;
    selFlitId = lFlitId;
    case (grant)
      psLocal: {selReq, selData, selFlitId} = {lReq, lData, lFlitId};
      psNorth: {selReq, selData, selFlitId} = {nReq, nData, nFlitId};
      psEast:  {selReq, selData, selFlitId} = {eReq, eData, eFlitId};
      psWest:  {selReq, selData, selFlitId} = {wReq, wData, wFlitId};
      psSouth: {selReq, selData, selFlitId} = {sReq, sData, sFlitId};
      default: selReq = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selReq;
  end

  // data holds its last value when nothing moves.
  always_ff @(posedge clk)
  begin
    if (selReq)
    begin
      outData   <= selData;
      outFlitId <= selFlitId;
    end
  end

  assert property (@(posedge clk) disable iff (rst) (grant == psIdle) |=> !outValid)
  else
    $error("flitForward: valid flit after an idle grant");

endmodule

//--- logic/outPort.sv
`timescale 1ns/1ps

`include "router_macros.svh"

module outPort
  import routerPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lReq,
  input  logic [`FLIT_ID_W-1:0] lFlitId,
  input  logic [`LEN_W-1:0]     lLength,
  input  logic [`DATA_W-1:0]    lData,
  input  logic                  nReq,
  input  logic [`FLIT_ID_W-1:0] nFlitId,
  input  logic [`LEN_W-1:0]     nLength,
  input  logic [`DATA_W-1:0]    nData,
  input  logic                  eReq,
  input  logic [`FLIT_ID_W-1:0] eFlitId,
  input  logic [`LEN_W-1:0]     eLength,
  input  logic [`DATA_W-1:0]    eData,
  input  logic                  wReq,
  input  logic [`FLIT_ID_W-1:0] wFlitId,
  input  logic [`LEN_W-1:0]     wLength,
  input  logic [`DATA_W-1:0]    wData,
  input  logic                  sReq,
  input  logic [`FLIT_ID_W-1:0] sFlitId,
  input  logic [`LEN_W-1:0]     sLength,
  input  logic [`DATA_W-1:0]    sData,
  output portSel                grant,
  output logic [`DATA_W-1:0]    outData,
  output logic [`FLIT_ID_W-1:0] outFlitId,
  output logic                  outValid
);

  // ********************
  // switch arbiter
  // ********************

  switchArbiter i_arbiter (
    .clk     (clk),
    .rst     (rst),
    .lReq    (lReq),
    .nReq    (nReq),
    .eReq    (eReq),
    .wReq    (wReq),
    .sReq    (sReq),
    .lFlitId (lFlitId),
    .nFlitId (nFlitId),
    .eFlitId (eFlitId),
    .wFlitId (wFlitId),
    .sFlitId (sFlitId),
    .lLength (lLength),
    .nLength (nLength),
    .eLength (eLength),
    .wLength (wLength),
    .sLength (sLength),
    .grant   (grant)
  );

  // ********************
  // output register
  // ********************

  // forwards the flit of whoever holds the grant.
  flitForward i_forward (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .lReq      (lReq),
    .nReq      (nReq),
    .eReq      (eReq),
    .wReq      (wReq),
    .sReq      (sReq),
    .lData     (lData),
    .nData     (nData),
    .eData     (eData),
    .wData     (wData),
    .sData     (sData),
    .lFlitId   (lFlitId),
    .nFlitId   (nFlitId),
    .eFlitId   (eFlitId),
    .wFlitId   (wFlitId),
    .sFlitId   (sFlitId),
    .outData   (outData),
    .outFlitId (outFlitId),
    .outValid  (outValid)
  );

endmodule

//--- tb/outPortModel.svh
`ifndef OUT_PORT_MODEL_SVH
`define OUT_PORT_MODEL_SVH

// ********************
// reference model
// ********************

portSel                   mState;
logic [4:0][`LEN_W-1:0]   mCount;
logic [4:0][`LEN_W-1:0]   mLimit;
logic                     expValid;
logic                     dataKnown;
logic [`DATA_W-1:0]       expData;
logic [`FLIT_ID_W-1:0]    expFlitId;

// input index in L, N, E, W, S order to its grant value.
function automatic portSel portOf(input int idx);
  case (idx)
    0: return psLocal;
    1: return psNorth;
    2: return psEast;
    3: return psWest;
    default: return psSouth;
  endcase
endfunction

function void resetModel();
  mState    = psIdle;
  mCount    = '0;
  mLimit    = '0;
  expValid  = 1'b0;
  dataKnown = 1'b0;
endfunction

// advances the model by one clock edge from the inputs of this cycle.
function void stepModel(input logic [4:0] reqs, input logic [4:0][`FLIT_ID_W-1:0] ids,
                        input logic [4:0][`LEN_W-1:0] lens,
                        input logic [4:0][`DATA_W-1:0] dataIn);
  int     holder;
  int     cand;
  logic   keep;
  logic   found;
  portSel next;
  holder = -1;
  for (int i = 0; i < 5; i++)
    if (mState == portOf(i))
      holder = i;
  // the holder keeps the output until it drops or its time is up.
  keep  = (holder >= 0) && reqs[holder] && (mCount[holder] != mLimit[holder]);
  next  = keep ? mState : psIdle;
  found = keep;
  for (int k = 1; k <= 5; k++)
  begin
    cand = (holder + k) % 5;
    if (!found && reqs[cand])
    begin
      next  = portOf(cand);
      found = 1'b1;
    end
  end
  // output register, one cycle behind the grant.
  expValid = (holder >= 0) && reqs[holder];
  if (expValid)
  begin
    expData   = dataIn[holder];
    expFlitId = ids[holder];
    dataKnown = 1'b1;
  end
  for (int i = 0; i < 5; i++)
  begin
    if (ids[i] == fkHeader)
      mLimit[i] = lens[i];
    mCount[i] = (keep && i == holder) ? mCount[i] + 1'b1 : '0;
  end
  mState = next;
endfunction

// compares one value and reports a mismatch.
task checkValue(input string name, input logic [31:0] expected, input logic [31:0] actual);
  if (actual !== expected)
  begin
    errorCount++;
    $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
  end
endtask

`endif

//--- tb/outPortTb.sv
`timescale 1ns/1ps

`include "router_macros.svh"

module outPortTb
  import routerPkg::*;
;

  localparam int DIRECTED_CYCLES = 60;
  localparam int RANDOM_CYCLES   = 500;
  localparam int TIMEOUT_CYCLES  = DIRECTED_CYCLES + RANDOM_CYCLES + 50;

  logic                        clk;
  logic                        rst;
  logic [4:0]                  req;
  logic [4:0][`FLIT_ID_W-1:0]  flitIds;
  logic [4:0][`LEN_W-1:0]      lens;
  logic [4:0][`DATA_W-1:0]     words;
  portSel                      grant;
  logic [`DATA_W-1:0]          outData;
  logic [`FLIT_ID_W-1:0]       outFlitId;
  logic                        outValid;
  int                          errorCount = 0;
  int                          cycleCount = 0;
  logic [31:0]                 lcgState = 32'd65;

`include "outPortModel.svh"

  outPort i_dut (
    .clk(clk), .rst(rst),
    .lReq(req[0]), .lFlitId(flitIds[0]), .lLength(lens[0]), .lData(words[0]),
    .nReq(req[1]), .nFlitId(flitIds[1]), .nLength(lens[1]), .nData(words[1]),
    .eReq(req[2]), .eFlitId(flitIds[2]), .eLength(lens[2]), .eData(words[2]),
    .wReq(req[3]), .wFlitId(flitIds[3]), .wLength(lens[3]), .wData(words[3]),
    .sReq(req[4]), .sFlitId(flitIds[4]), .sLength(lens[4]), .sData(words[4]),
    .grant(grant), .outData(outData), .outFlitId(outFlitId), .outValid(outValid)
  );

  function logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // inputs change 2 ns after the rising edge, with fresh flit words.
  task nextCycle();
    @(posedge clk);
    #2;
    for (int i = 0; i < 5; i++)
      words[i] = nextRand();
  endtask

  task clearInputs();
    req = '0;
    for (int i = 0; i < 5; i++)
    begin
      flitIds[i] = fkBody;
      lens[i]    = '0;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ********************
  // monitor
  // ********************

  // sampled mid-cycle, where inputs and outputs are settled.
  always @(negedge clk)
  begin
    if (rst)
      resetModel();
    else
    begin
      checkValue("grant", mState, grant);
      checkValue("outValid", expValid, outValid);
      if (dataKnown)
      begin
        checkValue("outData", expData, outData);
        checkValue("outFlitId", expFlitId, outFlitId);
      end
      stepModel(req, flitIds, lens, words);
    end
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  // ********************
  // stimulus
  // ********************

  initial
  begin
    logic [31:0] r;
    int          hits;
    rst   = 1'b1;
    words = '0;
    clearInputs();
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    // idle, then everybody asks at once.
    repeat (3) nextCycle();
    req = 5'b11111;
    @(negedge clk);
    @(negedge clk);
    checkValue("grant", psLocal, grant);

    // local header of length 3 holds for four cycles.
    nextCycle();
    clearInputs();
    repeat (4) nextCycle();
    req        = 5'b00011;
    flitIds[0] = fkHeader;
    lens[0]    = 12'd3;
    hits       = 0;
    repeat (6)
    begin
      @(negedge clk);
      if (grant == psLocal)
        hits++;
    end
    checkValue("local hold cycles", 32'd4, hits);
    checkValue("grant", psNorth, grant);

    // west drops, rotation wraps past south to local.
    nextCycle();
    clearInputs();
    repeat (4) nextCycle();
    req[3]     = 1'b1;
    flitIds[3] = fkHeader;
    lens[3]    = 12'd7;
    repeat (3) nextCycle();
    req = 5'b00011;
    @(negedge clk);
    @(negedge clk);
    checkValue("grant", psLocal, grant);

    // zero length yields at once, a new header sets a new limit.
    // north wins from idle, then east gets one cycle and hands back to north.
    nextCycle();
    clearInputs();
    repeat (4) nextCycle();
    req        = 5'b00110;
    flitIds[2] = fkHeader;
    lens[2]    = 12'd0;
    repeat (4) @(negedge clk);
    checkValue("grant", psNorth, grant);
    nextCycle();
    req     = 5'b00100;
    lens[2] = 12'd2;
    repeat (6) nextCycle();

    // random traffic, mostly requesting.
    for (int n = 0; n < RANDOM_CYCLES; n++)
    begin
      nextCycle();
      for (int i = 0; i < 5; i++)
      begin
        r          = nextRand();
        req[i]     = (r[30:28] != 3'd0);
        flitIds[i] = (r[25:24] == 2'd0) ? fkHeader : (r[23] ? fkTail : fkBody);
        lens[i]    = r[18:16];
      end
    end

    nextCycle();
    clearInputs();
    repeat (2) nextCycle();
    $display("errors: %0d", errorCount);
    if (errorCount == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- outPort.f
+incdir+common
+incdir+tb
common/routerPkg.sv
arbiter/grantTimer.sv
arbiter/switchArbiter.sv
logic/flitForward.sv
logic/outPort.sv
tb/outPortTb.sv
